// File: hw/proto_pkg.sv
package proto_pkg;

    // UART bit timing, both directions
    localparam int clks_per_bit = 16;

    // Depth of the acknowledgement queue
    localparam int ack_depth = 4;

    // Command header codes
    localparam logic [7:0] hdr_duty0 = 8'hAA; // Signed duty, motor 0
    localparam logic [7:0] hdr_duty1 = 8'hBB; // Signed duty, motor 1
    localparam logic [7:0] hdr_psc   = 8'hCC; // Prescaler
    localparam logic [7:0] hdr_ccr   = 8'hDD; // Period
    localparam logic [7:0] hdr_query = 8'hEE; // One-byte query, echo only

    // One byte with its strobe
    typedef struct packed {
        logic       valid;
        logic [7:0] data;
    } byte_beat_t;

    // Two payload bytes of a frame, high byte first on the wire
    typedef union packed {
        logic signed [15:0] duty;  // Duty commands
        logic        [15:0] count; // Prescaler and period commands
    } cmd_payload_u;

endpackage

// File: hw/motor_pkg.sv
package motor_pkg;

    // Width of duty, prescaler and period follows the frame payload
    localparam int pwm_w = $bits(proto_pkg::cmd_payload_u);
    localparam int num_motors = 2;

    localparam logic [pwm_w-1:0] psc_default = pwm_w'(99);
    localparam logic [pwm_w-1:0] ccr_default = pwm_w'(999);

    typedef logic signed [pwm_w-1:0] duty_t;

    typedef struct packed {
        logic [pwm_w-1:0]           psc;
        logic [pwm_w-1:0]           ccr;
        duty_t [num_motors-1:0]     duty; // Index 0 is motor 0
    } motor_cfg_t;

    typedef enum logic [1:0] {
        dir_stop = 2'b00,
        dir_fwd  = 2'b01,
        dir_rev  = 2'b10
    } dir_t;

    // Absolute value, one bit wider so that -32768 survives
    function automatic logic [pwm_w:0] duty_mag(input duty_t d);
        logic signed [pwm_w:0] d_ext;
        d_ext = d;
        return (d_ext < 0) ? -d_ext : d_ext;
    endfunction

endpackage

// File: hw/uart_rx.sv
module uart_rx (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   rx,
    output proto_pkg::byte_beat_t  rx_beat
);

    typedef enum logic [1:0] {
        rx_idle,
        rx_start,
        rx_data,
        rx_stop
    } rx_state_t;

    rx_state_t state;
    logic [1:0] sync_q;
    logic rx_s;
    logic [$clog2(proto_pkg::clks_per_bit)-1:0] cnt;
    logic [2:0] bit_idx;
    logic [7:0] shift_q;
    logic valid_q;

    assign rx_s = sync_q[1];
    assign rx_beat = '{valid: valid_q, data: shift_q};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sync_q  <= 2'b11; // Line idles high
            state   <= rx_idle;
            cnt     <= '0;
            bit_idx <= '0;
            valid_q <= 1'b0;
        end else begin
            sync_q  <= {sync_q[0], rx};
            valid_q <= 1'b0;
            cnt     <= cnt + 1'b1;
            case (state)
                rx_idle: begin
                    cnt <= '0;
                    if (!rx_s) state <= rx_start;
                end
                rx_start: begin
                    // Centre check pulled in by the synchroniser latency
                    if (cnt == proto_pkg::clks_per_bit / 2 - 2) begin
                        cnt     <= '0;
                        bit_idx <= '0;
                        state   <= rx_s ? rx_idle : rx_data; // Glitch, not a start bit
                    end
                end
                rx_data: begin
                    if (cnt == proto_pkg::clks_per_bit - 1) begin
                        cnt     <= '0;
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7) state <= rx_stop;
                    end
                end
                default: begin
                    if (cnt == proto_pkg::clks_per_bit - 1) begin
                        valid_q <= rx_s; // Framing error drops the byte
                        state   <= rx_idle;
                    end
                end
            endcase
        end
    end

    // LSB first
    always_ff @(posedge clk) begin
        if (state == rx_data && cnt == proto_pkg::clks_per_bit - 1) shift_q <= {rx_s, shift_q[7:1]};
    end

endmodule

// File: hw/cmd_parser.sv
module cmd_parser (
    input  logic                   clk,
    input  logic                   rst_n,
    input  proto_pkg::byte_beat_t  rx_beat,
    output motor_pkg::motor_cfg_t  cfg,
    output proto_pkg::byte_beat_t  ack_push
);

    typedef enum logic [1:0] {
        st_hdr,
        st_hi,
        st_lo
    } parse_state_t;

    parse_state_t state;
    logic [7:0] cmd_q;
    logic [7:0] hi_q;
    logic last_beat;
    logic [motor_pkg::num_motors-1:0] duty_wr;
    proto_pkg::cmd_payload_u payload;

    // Saturate a requested duty to +-ccr
    function automatic motor_pkg::duty_t clamp_duty(
        input motor_pkg::duty_t          duty,
        input logic [motor_pkg::pwm_w-1:0] ccr
    );
        logic signed [motor_pkg::pwm_w:0] d_ext;
        logic signed [motor_pkg::pwm_w:0] lim;
        d_ext = duty;
        lim   = $signed({1'b0, ccr});
        if (d_ext > lim) return motor_pkg::duty_t'(lim);
        if (d_ext < -lim) return motor_pkg::duty_t'(-lim);
        return duty;
    endfunction

    assign last_beat  = rx_beat.valid && (state == st_lo);
    assign payload    = {hi_q, rx_beat.data};
    assign duty_wr[0] = last_beat && (cmd_q == proto_pkg::hdr_duty0);
    assign duty_wr[1] = last_beat && (cmd_q == proto_pkg::hdr_duty1);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= st_hdr;
            cmd_q    <= '0;
            cfg.psc  <= motor_pkg::psc_default;
            cfg.ccr  <= motor_pkg::ccr_default;
            cfg.duty <= '0;
            ack_push <= '0;
        end else begin
            ack_push.valid <= 1'b0;
            if (rx_beat.valid) begin
                case (state)
                    st_hdr: begin
                        cmd_q <= rx_beat.data;
                        if (rx_beat.data == proto_pkg::hdr_query) begin
                            ack_push <= '{valid: 1'b1, data: rx_beat.data};
                        end else if (rx_beat.data == proto_pkg::hdr_duty0
                                     || rx_beat.data == proto_pkg::hdr_duty1
                                     || rx_beat.data == proto_pkg::hdr_psc
                                     || rx_beat.data == proto_pkg::hdr_ccr) begin
                            state <= st_hi;
                        end // Anything else is line noise
                    end
                    st_hi: state <= st_lo;
                    default: begin
                        state    <= st_hdr;
                        ack_push <= '{valid: 1'b1, data: cmd_q};
                        if (cmd_q == proto_pkg::hdr_psc) cfg.psc <= payload.count;
                        if (cmd_q == proto_pkg::hdr_ccr) cfg.ccr <= payload.count;
                        for (int i = 0; i < motor_pkg::num_motors; i++) begin
                            if (duty_wr[i]) cfg.duty[i] <= clamp_duty(payload.duty, cfg.ccr);
                        end
                    end
                endcase
            end
        end
    end

    // High byte waits for its partner
    always_ff @(posedge clk) begin
        if (rx_beat.valid && state == st_hi) hi_q <= rx_beat.data;
    end

    // Clamp holds against the period in force when the duty was taken
    for (genvar i = 0; i < motor_pkg::num_motors; i++) begin : g_clamp_chk
        a_duty_clamped: assert property (@(posedge clk) disable iff (!rst_n)
            duty_wr[i] |=> motor_pkg::duty_mag(cfg.duty[i]) <= {1'b0, $past(cfg.ccr)});
    end

endmodule

// File: hw/ack_fifo.sv
module ack_fifo (
    input  logic                   clk,
    input  logic                   rst_n,
    input  proto_pkg::byte_beat_t  ack_push,
    output logic                   tx_valid,
    output logic [7:0]             tx_data,
    input  logic                   tx_ready
);

    localparam int ptr_w = $clog2(proto_pkg::ack_depth);

    logic [7:0] mem [proto_pkg::ack_depth];
    logic [ptr_w-1:0] wr_ptr;
    logic [ptr_w-1:0] rd_ptr;
    logic [ptr_w:0] count;
    logic [ptr_w:0] count_nxt;
    logic push;
    logic pop;

    assign push    = ack_push.valid && (count != proto_pkg::ack_depth); // Full drops it
    assign pop     = tx_valid && tx_ready;
    assign tx_data = mem[rd_ptr];

    always_comb begin
        count_nxt = count;
        if (push && !pop) count_nxt = count + 1'b1;
        if (pop && !push) count_nxt = count - 1'b1;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            tx_valid <= 1'b0;
        end else begin
            if (push) wr_ptr <= wr_ptr + 1'b1;
            if (pop) rd_ptr <= rd_ptr + 1'b1;
            count    <= count_nxt;
            tx_valid <= (count_nxt != 0);
        end
    end

    always_ff @(posedge clk) begin
        if (push) mem[wr_ptr] <= ack_push.data;
    end

    a_count_max: assert property (@(posedge clk) disable iff (!rst_n)
        count <= proto_pkg::ack_depth);
    a_empty_quiet: assert property (@(posedge clk) disable iff (!rst_n)
        (count == 0) |-> !tx_valid);

endmodule

// File: hw/uart_tx.sv
module uart_tx (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       tx_valid,
    input  logic [7:0] tx_data,
    output logic       tx_ready,
    output logic       tx
);

    logic busy;
    logic tx_q;
    logic tick;
    logic [8:0] frame_q; // Data bits then stop
    logic [3:0] bits_left;
    logic [$clog2(proto_pkg::clks_per_bit)-1:0] cnt;

    assign tx_ready = !busy;
    assign tx       = tx_q;
    assign tick     = busy && (cnt == proto_pkg::clks_per_bit - 1);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy      <= 1'b0;
            tx_q      <= 1'b1;
            cnt       <= '0;
            bits_left <= '0;
        end else if (!busy) begin
            if (tx_valid) begin
                busy      <= 1'b1;
                tx_q      <= 1'b0; // Start bit
                cnt       <= '0;
                bits_left <= 4'd9;
            end
        end else if (tick) begin
            cnt <= '0;
            if (bits_left == 0) begin
                busy <= 1'b0; // Stop bit done
            end else begin
                tx_q      <= frame_q[0];
                bits_left <= bits_left - 1'b1;
            end
        end else begin
            cnt <= cnt + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!busy && tx_valid) begin
            frame_q <= {1'b1, tx_data};
        end else if (tick && bits_left != 0) begin
            frame_q <= {1'b1, frame_q[8:1]}; // LSB first
        end
    end

endmodule

// File: hw/pwm_gen.sv
module pwm_gen (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic [motor_pkg::pwm_w-1:0]   cfg_psc,
    input  logic [motor_pkg::pwm_w-1:0]   cfg_ccr,
    input  motor_pkg::duty_t              duty,
    output logic                          pwm_out,
    output motor_pkg::dir_t               motor_dir
);

    logic [motor_pkg::pwm_w-1:0] psc_cnt, psc_nxt;
    logic [motor_pkg::pwm_w-1:0] per_cnt, per_nxt;
    logic [motor_pkg::pwm_w-1:0] psc_sh;
    logic [motor_pkg::pwm_w-1:0] ccr_sh;
    motor_pkg::duty_t duty_sh;
    motor_pkg::duty_t duty_nxt;
    logic wrap;

    always_comb begin
        psc_nxt = psc_cnt + 1'b1;
        per_nxt = per_cnt;
        wrap    = 1'b0;
        if (psc_cnt == psc_sh) begin
            psc_nxt = '0;
            if (per_cnt == ccr_sh) begin
                per_nxt = '0;
                wrap    = 1'b1;
            end else begin
                per_nxt = per_cnt + 1'b1;
            end
        end
        duty_nxt = wrap ? duty : duty_sh; // New duty applies from the first count
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            psc_cnt <= '0;
            per_cnt <= '0;
            psc_sh  <= motor_pkg::psc_default;
            ccr_sh  <= motor_pkg::ccr_default;
            duty_sh <= '0;
            pwm_out <= 1'b0;
        end else begin
            psc_cnt <= psc_nxt;
            per_cnt <= per_nxt;
            if (wrap) begin
                psc_sh <= cfg_psc;
                ccr_sh <= cfg_ccr;
            end
            duty_sh <= duty_nxt;
            pwm_out <= ({1'b0, per_nxt} < motor_pkg::duty_mag(duty_nxt));
        end
    end

    always_comb begin
        if (duty_sh > 0) motor_dir = motor_pkg::dir_fwd;
        else if (duty_sh < 0) motor_dir = motor_pkg::dir_rev;
        else motor_dir = motor_pkg::dir_stop;
    end

    a_zero_duty_low: assert property (@(posedge clk) disable iff (!rst_n)
        (duty_sh == 0) |-> !pwm_out);

endmodule

// File: hw/motor_ctrl_top.sv
module motor_ctrl_top (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       rx,
    output logic       tx,
    output logic [1:0] pwm_out,
    output logic [3:0] motor_dir // Motor 1 in [3:2]
);

    proto_pkg::byte_beat_t rx_beat;
    proto_pkg::byte_beat_t ack_push;
    motor_pkg::motor_cfg_t cfg;
    logic tx_valid;
    logic tx_ready;
    logic [7:0] tx_data;

    uart_rx u_uart_rx (
        .clk     (clk),
        .rst_n   (rst_n),
        .rx      (rx),
        .rx_beat (rx_beat)
    );

    cmd_parser u_cmd_parser (
        .clk      (clk),
        .rst_n    (rst_n),
        .rx_beat  (rx_beat),
        .cfg      (cfg),
        .ack_push (ack_push)
    );

    // Acknowledgements wait here while the transmitter is busy
    ack_fifo u_ack_fifo (
        .clk      (clk),
        .rst_n    (rst_n),
        .ack_push (ack_push),
        .tx_valid (tx_valid),
        .tx_data  (tx_data),
        .tx_ready (tx_ready)
    );

    uart_tx u_uart_tx (
        .clk      (clk),
        .rst_n    (rst_n),
        .tx_valid (tx_valid),
        .tx_data  (tx_data),
        .tx_ready (tx_ready),
        .tx       (tx)
    );

    for (genvar i = 0; i < motor_pkg::num_motors; i++) begin : g_motor
        pwm_gen u_pwm_gen (
            .clk       (clk),
            .rst_n     (rst_n),
            .cfg_psc   (cfg.psc),
            .cfg_ccr   (cfg.ccr),
            .duty      (cfg.duty[i]),
            .pwm_out   (pwm_out[i]),
            .motor_dir (motor_dir[2*i +: 2])
        );
    end

endmodule

// File: test/tb_motor_ctrl.sv
module tb_motor_ctrl;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int cpb = proto_pkg::clks_per_bit;
    localparam int n_cmds = 46; // 6 directed and 40 random
    localparam int def_period =
        (int'(motor_pkg::psc_default) + 1) * (int'(motor_pkg::ccr_default) + 1);
    localparam int ack_limit = 60 * cpb; // Ack start bound plus the ack frame itself
    // Frames with junk and ack plus the slow default period and short random periods
    localparam int cycle_limit = 2 * (n_cmds * 100 * cpb + 3 * def_period + n_cmds * 500);

    logic clk;
    logic rst_n;
    logic rx;
    logic tx;
    logic [1:0] pwm_out;
    logic [3:0] motor_dir;
    logic [15:0] lfsr_q;
    int cycles;
    int psc_m;
    int ccr_m;
    int duty_m [2];
    logic [7:0] obs_q [$]; // Bytes seen on tx

    motor_ctrl_top dut_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .rx        (rx),
        .tx        (tx),
        .pwm_out   (pwm_out),
        .motor_dir (motor_dir)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    initial begin
        cycles = 0;
        while (cycles < cycle_limit) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout: the run went past %0d clock cycles", cycle_limit);
        $display("Simulation failed");
        $fatal(1, "Run aborted");
    end

    // x^16 + x^14 + x^13 + x^11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function automatic int take_bits(input int n);
        int v;
        v = 0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = lfsr_next(lfsr_q);
            v = (v << 1) | int'(lfsr_q[0]);
        end
        return v;
    endfunction

    // Zero one time in eight and otherwise -64 to 63
    function automatic int random_duty();
        if (take_bits(3) == 0) return 0;
        return take_bits(7) - 64;
    endfunction

    function automatic int clamp_to_period(input int d, input int ccr);
        return (d > ccr) ? ccr : (d < -ccr) ? -ccr : d;
    endfunction

    function automatic int dir_code(input int d);
        return (d > 0) ? 1 : (d < 0) ? 2 : 0; // 01 forward, 10 reverse
    endfunction

    task automatic check_eq(input int got, input int exp, input string what);
        if (got != exp) begin
            $display("MISMATCH at %0d ns: %s, got %0d, expected %0d", $time, what, got, exp);
            $display("Simulation failed");
            $fatal(1, "Stopped at first error");
        end
    endtask

    task automatic send_byte(input logic [7:0] b);
        rx = 1'b0; // Start bit
        repeat (cpb) @(negedge clk);
        for (int i = 0; i < 8; i++) begin
            rx = b[i];
            repeat (cpb) @(negedge clk);
        end
        rx = 1'b1;
        repeat (cpb) @(negedge clk);
    endtask

    task automatic wait_ack(input logic [7:0] hdr);
        int waited;
        waited = 0;
        while (obs_q.size() == 0 && waited < ack_limit) begin
            @(negedge clk);
            waited++;
        end
        if (obs_q.size() == 0) begin
            $display("No acknowledgement for header %02h within %0d cycles", hdr, ack_limit);
            $display("Simulation failed");
            $fatal(1, "Run aborted");
        end else begin
            check_eq(int'(obs_q.pop_front()), int'(hdr), "acknowledgement byte");
        end
    endtask

    // Old period may still run before the shadow load and one settled period follows
    task automatic check_pwm(input int prev_period);
        int period;
        int high [2];
        period = (psc_m + 1) * (ccr_m + 1);
        repeat (prev_period + period + 4) @(negedge clk);
        high[0] = 0;
        high[1] = 0;
        for (int m = 0; m < 2; m++) check_eq(int'(motor_dir[2*m +: 2]), dir_code(duty_m[m]),
                                             $sformatf("motor_dir of motor %0d", m));
        repeat (period) begin
            @(negedge clk);
            for (int m = 0; m < 2; m++) high[m] += int'(pwm_out[m]);
        end
        for (int m = 0; m < 2; m++) begin
            check_eq(high[m], (duty_m[m] < 0 ? -duty_m[m] : duty_m[m]) > ccr_m
                     ? (ccr_m + 1) * (psc_m + 1)
                     : (duty_m[m] < 0 ? -duty_m[m] : duty_m[m]) * (psc_m + 1),
                     $sformatf("pwm high cycles of motor %0d", m));
        end
    endtask

    task automatic run_command(input logic [7:0] hdr, input int value);
        int prev_period;
        prev_period = (psc_m + 1) * (ccr_m + 1);
        send_byte(hdr);
        if (hdr != proto_pkg::hdr_query) begin
            send_byte(value[15:8]); // High byte first
            send_byte(value[7:0]);
        end
        case (hdr)
            proto_pkg::hdr_duty0: duty_m[0] = clamp_to_period(value, ccr_m);
            proto_pkg::hdr_duty1: duty_m[1] = clamp_to_period(value, ccr_m);
            proto_pkg::hdr_psc:   psc_m = value;
            proto_pkg::hdr_ccr:   ccr_m = value; // Stored duties keep their values
            default: ;
        endcase
        wait_ack(hdr);
        if (hdr != proto_pkg::hdr_query) check_pwm(prev_period);
    endtask

    initial begin
        logic [7:0] b;
        @(posedge rst_n);
        forever begin
            @(negedge clk);
            if (tx == 1'b0) begin
                repeat (cpb / 2) @(negedge clk); // Centre of the start bit
                for (int i = 0; i < 8; i++) begin
                    repeat (cpb) @(negedge clk);
                    b[i] = tx;
                end
                repeat (cpb) @(negedge clk);
                if (tx != 1'b1) begin
                    $display("Framing error on tx: the stop bit was low at %0d ns", $time);
                    $display("Simulation failed");
                    $fatal(1, "Run aborted");
                end else begin
                    obs_q.push_back(b);
                end
            end
        end
    end

    initial begin
        int sel;
        rx = 1'b1;
        rst_n = 1'b0;
        lfsr_q = 16'd53;
        psc_m = int'(motor_pkg::psc_default);
        ccr_m = int'(motor_pkg::ccr_default);
        duty_m[0] = 0;
        duty_m[1] = 0;
        repeat (10) @(negedge clk);
        rst_n = 1'b1;
        repeat (100) begin
            @(negedge clk);
            check_eq(int'(tx), 1, "tx after reset");
            check_eq(int'(pwm_out), 0, "pwm_out after reset");
            check_eq(int'(motor_dir), 0, "motor_dir after reset");
        end
        run_command(proto_pkg::hdr_psc, 1);
        run_command(proto_pkg::hdr_ccr, 40);
        run_command(proto_pkg::hdr_duty0, 35);
        run_command(proto_pkg::hdr_duty1, -50); // Saturates at -40
        run_command(proto_pkg::hdr_ccr, 10);    // Shrinks below both duties
        run_command(proto_pkg::hdr_query, 0);
        for (int n = 0; n < n_cmds - 6; n++) begin
            if (take_bits(2) == 0) send_byte(8'h5A ^ 8'(take_bits(3))); // Never a header
            sel = take_bits(3);
            if (sel < 2) run_command(proto_pkg::hdr_duty0, random_duty());
            else if (sel < 4) run_command(proto_pkg::hdr_duty1, random_duty());
            else if (sel == 4) run_command(proto_pkg::hdr_psc, take_bits(2));
            else if (sel < 7) run_command(proto_pkg::hdr_ccr, 8 + take_bits(6) % 33);
            else run_command(proto_pkg::hdr_query, 0);
        end
        repeat (ack_limit) @(negedge clk);
        check_eq(obs_q.size(), 0, "acknowledgements left over at the end");
        $display("Simulation passed");
        $finish;
    end

endmodule

// File: flist.f
hw/proto_pkg.sv
hw/motor_pkg.sv
hw/uart_rx.sv
hw/cmd_parser.sv
hw/ack_fifo.sv
hw/uart_tx.sv
hw/pwm_gen.sv
hw/motor_ctrl_top.sv
test/tb_motor_ctrl.sv

// File: Makefile
TOOL  = verilator
FLAGS = --binary --timing --assert -j 0
TOP   = tb_motor_ctrl
FLIST = flist.f

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FLIST)
	out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -q "Simulation passed"

clean:
	rm -rf obj_dir

.PHONY: sim clean
